//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = axi_id_xbar_tb
FILE_LIST = all.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
source/axi_xbar_pkg.sv
source/axi_read_addr_router.sv
source/axi_read_resp_router.sv
source/axi_write_req_router.sv
source/axi_write_resp_router.sv
source/axi_id_xbar.sv
test/axi_id_xbar_assert.sv
test/axi_id_xbar_checker.sv
test/axi_id_xbar_tb.sv

//--- source/axi_id_xbar.sv
`timescale 1ns/1ps

module axi_id_xbar import axi_xbar_pkg::*; (
    // clock and reset reach only the bound checks
    input  logic                   aclk,
    input  logic                   reset,

    // master 0, read only
    input  addr_req_t              m0_ar,
    input  logic                   m0_arvalid,
    output logic                   m0_arready,
    output r_beat_t                m0_r,
    output logic                   m0_rvalid,
    input  logic                   m0_rready,

    // master 1
    input  addr_req_t              m1_aw,
    input  logic                   m1_awvalid,
    output logic                   m1_awready,
    input  w_beat_t                m1_w,
    input  logic                   m1_wvalid,
    output logic                   m1_wready,
    output b_beat_t                m1_b,
    output logic                   m1_bvalid,
    input  logic                   m1_bready,
    input  addr_req_t              m1_ar,
    input  logic                   m1_arvalid,
    output logic                   m1_arready,
    output r_beat_t                m1_r,
    output logic                   m1_rvalid,
    input  logic                   m1_rready,

    // slaves
    output addr_req_t              s_aw [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_awvalid,
    input  logic [NUM_SLAVES-1:0]  s_awready,
    output w_beat_t                s_w [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_wvalid,
    input  logic [NUM_SLAVES-1:0]  s_wready,
    input  b_beat_t                s_b [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_bvalid,
    output logic [NUM_SLAVES-1:0]  s_bready,
    output addr_req_t              s_ar [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_arvalid,
    input  logic [NUM_SLAVES-1:0]  s_arready,
    input  r_beat_t                s_r [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_rvalid,
    output logic [NUM_SLAVES-1:0]  s_rready
);

    //**************************************************
    // read path
    //**************************************************
    axi_read_addr_router u_read_addr_router (
        .m0_ar      (m0_ar),
        .m0_arvalid (m0_arvalid),
        .m0_arready (m0_arready),
        .m1_ar      (m1_ar),
        .m1_arvalid (m1_arvalid),
        .m1_arready (m1_arready),
        .s_ar       (s_ar),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready)
    );

    axi_read_resp_router u_read_resp_router (
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m0_r      (m0_r),
        .m0_rvalid (m0_rvalid),
        .m0_rready (m0_rready),
        .m1_r      (m1_r),
        .m1_rvalid (m1_rvalid),
        .m1_rready (m1_rready)
    );

    //**************************************************
    // write path, master 1 only
    //**************************************************
    axi_write_req_router u_write_req_router (
        .m1_aw      (m1_aw),
        .m1_awvalid (m1_awvalid),
        .m1_awready (m1_awready),
        .m1_w       (m1_w),
        .m1_wvalid  (m1_wvalid),
        .m1_wready  (m1_wready),
        .s_aw       (s_aw),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_w        (s_w),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready)
    );

    axi_write_resp_router u_write_resp_router (
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .m1_b      (m1_b),
        .m1_bvalid (m1_bvalid),
        .m1_bready (m1_bready)
    );

endmodule

//--- source/axi_read_addr_router.sv
`timescale 1ns/1ps

module axi_read_addr_router import axi_xbar_pkg::*; (
    input  addr_req_t              m0_ar,
    input  logic                   m0_arvalid,
    output logic                   m0_arready,
    input  addr_req_t              m1_ar,
    input  logic                   m1_arvalid,
    output logic                   m1_arready,
    output addr_req_t              s_ar [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_arvalid,
    input  logic [NUM_SLAVES-1:0]  s_arready
);

    // idle master holds its ARID at zero, so the OR names the requester
    id_t                   arid_or;
    logic [NUM_SLAVES-1:0] master_sel;
    logic [NUM_SLAVES-1:0] slave_sel;
    addr_req_t             ar_merged;
    logic                  arvalid_merged;
    logic                  arready_sel;

    assign arid_or    = m0_ar.id | m1_ar.id;
    assign master_sel = route_sel(master_route(arid_or));
    assign slave_sel  = route_sel(slave_route(arid_or));

    //**************************************************
    // master merge
    //**************************************************
    always_comb begin
        ar_merged      = '0;
        arvalid_merged = 1'b0;
        if (master_sel[0]) begin
            ar_merged      = m0_ar;
            arvalid_merged = m0_arvalid;
        end else if (master_sel[1]) begin
            ar_merged      = m1_ar;
            arvalid_merged = m1_arvalid;
        end
    end

    //**************************************************
    // slave steering
    //**************************************************
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_ar[i]      = slave_sel[i] ? ar_merged : '0;
            s_arvalid[i] = slave_sel[i] & arvalid_merged;
        end
    end

    // ready only from the addressed slave
    assign arready_sel = |(slave_sel & s_arready);

    assign m0_arready = master_sel[0] & arready_sel;
    assign m1_arready = master_sel[1] & arready_sel;

endmodule

//--- source/axi_read_resp_router.sv
`timescale 1ns/1ps

module axi_read_resp_router import axi_xbar_pkg::*; (
    input  r_beat_t                s_r [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_rvalid,
    output logic [NUM_SLAVES-1:0]  s_rready,
    output r_beat_t                m0_r,
    output logic                   m0_rvalid,
    input  logic                   m0_rready,
    output r_beat_t                m1_r,
    output logic                   m1_rvalid,
    input  logic                   m1_rready
);

    id_t                   rid_or;
    logic [NUM_SLAVES-1:0] slave_sel;
    logic [NUM_SLAVES-1:0] master_sel;
    r_beat_t               r_merged;
    logic                  rvalid_merged;
    logic                  rready_sel;

    // silent slaves drive zero RIDs
    always_comb begin
        rid_or = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            rid_or = rid_or | s_r[i].id;
        end
    end

    assign slave_sel  = route_sel(slave_route(rid_or));
    assign master_sel = route_sel(master_route(rid_or));

    //**************************************************
    // slave merge
    //**************************************************
    always_comb begin
        r_merged = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (slave_sel[i]) begin
                r_merged = s_r[i];
            end
        end
    end

    assign rvalid_merged = |(slave_sel & s_rvalid);

    //**************************************************
    // master delivery
    //**************************************************
    assign m0_r      = master_sel[0] ? r_merged : '0;
    assign m0_rvalid = master_sel[0] & rvalid_merged;
    assign m1_r      = master_sel[1] ? r_merged : '0;
    assign m1_rvalid = master_sel[1] & rvalid_merged;

    // third master code has no port and never gives ready
    assign rready_sel = (master_sel[0] & m0_rready) | (master_sel[1] & m1_rready);

    assign s_rready = slave_sel & {NUM_SLAVES{rready_sel}};

endmodule

//--- source/axi_write_req_router.sv
`timescale 1ns/1ps

module axi_write_req_router import axi_xbar_pkg::*; (
    input  addr_req_t              m1_aw,
    input  logic                   m1_awvalid,
    output logic                   m1_awready,
    input  w_beat_t                m1_w,
    input  logic                   m1_wvalid,
    output logic                   m1_wready,
    output addr_req_t              s_aw [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_awvalid,
    input  logic [NUM_SLAVES-1:0]  s_awready,
    output w_beat_t                s_w [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_wvalid,
    input  logic [NUM_SLAVES-1:0]  s_wready
);

    // only master 1 writes, so only its code opens either channel
    logic                  aw_from_m1;
    logic                  w_from_m1;
    logic [NUM_SLAVES-1:0] aw_slave_sel;
    logic [NUM_SLAVES-1:0] w_slave_sel;
    logic [NUM_SLAVES-1:0] aw_route;
    logic [NUM_SLAVES-1:0] w_route;

    assign aw_from_m1   = (master_route(m1_aw.id) == ROUTE_1);
    assign w_from_m1    = (master_route(m1_w.id) == ROUTE_1);
    assign aw_slave_sel = route_sel(slave_route(m1_aw.id));
    assign w_slave_sel  = route_sel(slave_route(m1_w.id));

    // per-slave enables with the master check folded in
    assign aw_route = aw_slave_sel & {NUM_SLAVES{aw_from_m1}};
    assign w_route  = w_slave_sel & {NUM_SLAVES{w_from_m1}};

    //**************************************************
    // write address channel
    //**************************************************
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_aw[i]      = aw_route[i] ? m1_aw : '0;
            s_awvalid[i] = aw_route[i] & m1_awvalid;
        end
    end

    // SIZE goes through with the rest of the struct
    assign m1_awready = |(aw_route & s_awready);

    //**************************************************
    // write data channel
    //**************************************************
    // steered by WID alone, independent of the address channel
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_w[i]      = w_route[i] ? m1_w : '0;
            s_wvalid[i] = w_route[i] & m1_wvalid;
        end
    end

    assign m1_wready = |(w_route & s_wready);

endmodule

//--- source/axi_write_resp_router.sv
`timescale 1ns/1ps

module axi_write_resp_router import axi_xbar_pkg::*; (
    input  b_beat_t                s_b [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_bvalid,
    output logic [NUM_SLAVES-1:0]  s_bready,
    output b_beat_t                m1_b,
    output logic                   m1_bvalid,
    input  logic                   m1_bready
);

    id_t                   bid_or;
    logic [NUM_SLAVES-1:0] slave_sel;
    logic                  to_m1;
    b_beat_t               b_merged;

    always_comb begin
        bid_or = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            bid_or = bid_or | s_b[i].id;
        end
    end

    assign slave_sel = route_sel(slave_route(bid_or));
    assign to_m1     = (master_route(bid_or) == ROUTE_1);

    always_comb begin
        b_merged = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (slave_sel[i]) begin
                b_merged = s_b[i];
            end
        end
    end

    // any other master code drops the response
    assign m1_b      = to_m1 ? b_merged : '0;
    assign m1_bvalid = to_m1 & |(slave_sel & s_bvalid);

    assign s_bready = slave_sel & {NUM_SLAVES{to_m1 & m1_bready}};

endmodule

//--- source/axi_xbar_pkg.sv
package axi_xbar_pkg;

    //**************************************************
    // bus widths
    //**************************************************
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;
    localparam int ID_WIDTH   = 6;
    localparam int NUM_SLAVES = 3;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [ID_WIDTH-1:0]   id_t;
    typedef logic [3:0]            len_t;
    typedef logic [2:0]            size_t;
    typedef logic [1:0]            burst_t;
    typedef logic [1:0]            resp_t;
    typedef logic [2:0]            route_t;

    // thermometer route codes, low field picks a slave, high field a master
    localparam route_t ROUTE_0 = 3'b001;
    localparam route_t ROUTE_1 = 3'b011;
    localparam route_t ROUTE_2 = 3'b111;

    //**************************************************
    // channel payloads
    //**************************************************
    // shared by AR and AW
    typedef struct packed {
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_t burst;
        id_t    id;
    } addr_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
        id_t   id;
    } w_beat_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
        id_t   id;
    } r_beat_t;

    typedef struct packed {
        resp_t resp;
        id_t   id;
    } b_beat_t;

    function automatic route_t slave_route(id_t id);
        return id[$bits(route_t)-1:0];
    endfunction

    function automatic route_t master_route(id_t id);
        return id[ID_WIDTH-1 -: $bits(route_t)];
    endfunction

    // one-hot select, unknown codes select nobody
    function automatic logic [NUM_SLAVES-1:0] route_sel(route_t code);
        logic [NUM_SLAVES-1:0] sel;
        case (code)
            ROUTE_0: sel = 3'b001;
            ROUTE_1: sel = 3'b010;
            ROUTE_2: sel = 3'b100;
            default: sel = '0;
        endcase
        return sel;
    endfunction

endpackage

//--- test/axi_id_xbar_assert.sv
`timescale 1ns/1ps

module axi_id_xbar_assert import axi_xbar_pkg::*; (
    input logic                  aclk,
    input logic                  reset,
    input logic [NUM_SLAVES-1:0] s_arvalid,
    input logic [NUM_SLAVES-1:0] s_awvalid,
    input logic [NUM_SLAVES-1:0] s_wvalid,
    input logic                  m0_rvalid,
    input logic                  m1_rvalid
);

    // a request never fans out to two slaves
    ar_single_slave: assert property (@(posedge aclk) disable iff (reset) $onehot0(s_arvalid))
        else $error("read address valid raised at more than one slave");
    aw_single_slave: assert property (@(posedge aclk) disable iff (reset) $onehot0(s_awvalid))
        else $error("write address valid raised at more than one slave");
    w_single_slave: assert property (@(posedge aclk) disable iff (reset) $onehot0(s_wvalid))
        else $error("write data valid raised at more than one slave");

    r_single_master: assert property (@(posedge aclk) disable iff (reset)
        !(m0_rvalid && m1_rvalid))
        else $error("read data valid raised at both masters");

endmodule

//--- test/axi_id_xbar_checker.sv
`timescale 1ns/1ps

module axi_id_xbar_checker import axi_xbar_pkg::*; (
    input  logic                  aclk,
    input  addr_req_t             m0_ar, m1_ar, m1_aw,
    input  w_beat_t               m1_w,
    input  logic                  m0_arvalid, m1_arvalid, m1_awvalid, m1_wvalid,
    input  logic                  m0_rready, m1_rready, m1_bready,
    input  logic [NUM_SLAVES-1:0] s_arready, s_awready, s_wready, s_rvalid, s_bvalid,
    input  r_beat_t               s_r [NUM_SLAVES],
    input  b_beat_t               s_b [NUM_SLAVES],
    input  logic                  m0_arready, m1_arready, m1_awready, m1_wready,
    input  logic                  m0_rvalid, m1_rvalid, m1_bvalid,
    input  r_beat_t               m0_r, m1_r,
    input  b_beat_t               m1_b,
    input  addr_req_t             s_ar [NUM_SLAVES],
    input  addr_req_t             s_aw [NUM_SLAVES],
    input  w_beat_t               s_w [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0] s_arvalid, s_awvalid, s_wvalid, s_rready, s_bready,
    output int                    error_count,
    output int                    check_count
);

    typedef struct packed {
        addr_req_t [NUM_SLAVES-1:0] s_ar;
        logic [NUM_SLAVES-1:0]      s_arvalid;
        logic                       m0_arready;
        logic                       m1_arready;
        r_beat_t                    m0_r;
        logic                       m0_rvalid;
        r_beat_t                    m1_r;
        logic                       m1_rvalid;
        logic [NUM_SLAVES-1:0]      s_rready;
        addr_req_t [NUM_SLAVES-1:0] s_aw;
        logic [NUM_SLAVES-1:0]      s_awvalid;
        logic                       m1_awready;
        w_beat_t [NUM_SLAVES-1:0]   s_w;
        logic [NUM_SLAVES-1:0]      s_wvalid;
        logic                       m1_wready;
        b_beat_t                    m1_b;
        logic                       m1_bvalid;
        logic [NUM_SLAVES-1:0]      s_bready;
    } xbar_out_t;

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // {known, index} for a thermometer code
    function automatic logic [2:0] route_index(route_t code);
        case (code)
            3'b001:  return 3'b100;
            3'b011:  return 3'b101;
            3'b111:  return 3'b110;
            default: return 3'b000;
        endcase
    endfunction

    //**************************************************
    // reference model
    //**************************************************
    function automatic xbar_out_t expected_outputs();
        xbar_out_t  e;
        id_t        id;
        logic       s_ok;
        logic       m_ok;
        logic [1:0] s_idx;
        logic [1:0] m_idx;
        e = '0;
        // read address, requester named by the ORed ARIDs
        id = m0_ar.id | m1_ar.id;
        {s_ok, s_idx} = route_index(id[2:0]);
        {m_ok, m_idx} = route_index(id[5:3]);
        if (s_ok && m_ok && m_idx == 2'd0) begin
            e.s_ar[s_idx]      = m0_ar;
            e.s_arvalid[s_idx] = m0_arvalid;
            e.m0_arready       = s_arready[s_idx];
        end else if (s_ok && m_ok && m_idx == 2'd1) begin
            e.s_ar[s_idx]      = m1_ar;
            e.s_arvalid[s_idx] = m1_arvalid;
            e.m1_arready       = s_arready[s_idx];
        end
        // read data back to a master
        id = s_r[0].id | s_r[1].id | s_r[2].id;
        {s_ok, s_idx} = route_index(id[2:0]);
        {m_ok, m_idx} = route_index(id[5:3]);
        if (s_ok && m_ok && m_idx == 2'd0) begin
            e.m0_r            = s_r[s_idx];
            e.m0_rvalid       = s_rvalid[s_idx];
            e.s_rready[s_idx] = m0_rready;
        end else if (s_ok && m_ok && m_idx == 2'd1) begin
            e.m1_r            = s_r[s_idx];
            e.m1_rvalid       = s_rvalid[s_idx];
            e.s_rready[s_idx] = m1_rready;
        end
        // write address and data, each by its own ID
        {s_ok, s_idx} = route_index(m1_aw.id[2:0]);
        if (s_ok && m1_aw.id[5:3] == 3'b011) begin
            e.s_aw[s_idx]      = m1_aw;
            e.s_awvalid[s_idx] = m1_awvalid;
            e.m1_awready       = s_awready[s_idx];
        end
        {s_ok, s_idx} = route_index(m1_w.id[2:0]);
        if (s_ok && m1_w.id[5:3] == 3'b011) begin
            e.s_w[s_idx]      = m1_w;
            e.s_wvalid[s_idx] = m1_wvalid;
            e.m1_wready       = s_wready[s_idx];
        end
        // write response, only master 1 can take it
        id = s_b[0].id | s_b[1].id | s_b[2].id;
        {s_ok, s_idx} = route_index(id[2:0]);
        if (s_ok && id[5:3] == 3'b011) begin
            e.m1_b            = s_b[s_idx];
            e.m1_bvalid       = s_bvalid[s_idx];
            e.s_bready[s_idx] = m1_bready;
        end
        return e;
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge aclk) begin
        xbar_out_t e;
        e = expected_outputs();
        compare("m0_arready", 64'(e.m0_arready), 64'(m0_arready));
        compare("m1_arready", 64'(e.m1_arready), 64'(m1_arready));
        compare("s_arvalid", 64'(e.s_arvalid), 64'(s_arvalid));
        compare("m0_r", 64'(e.m0_r), 64'(m0_r));
        compare("m0_rvalid", 64'(e.m0_rvalid), 64'(m0_rvalid));
        compare("m1_r", 64'(e.m1_r), 64'(m1_r));
        compare("m1_rvalid", 64'(e.m1_rvalid), 64'(m1_rvalid));
        compare("s_rready", 64'(e.s_rready), 64'(s_rready));
        compare("m1_awready", 64'(e.m1_awready), 64'(m1_awready));
        compare("s_awvalid", 64'(e.s_awvalid), 64'(s_awvalid));
        compare("m1_wready", 64'(e.m1_wready), 64'(m1_wready));
        compare("s_wvalid", 64'(e.s_wvalid), 64'(s_wvalid));
        compare("m1_b", 64'(e.m1_b), 64'(m1_b));
        compare("m1_bvalid", 64'(e.m1_bvalid), 64'(m1_bvalid));
        compare("s_bready", 64'(e.s_bready), 64'(s_bready));
        for (int i = 0; i < NUM_SLAVES; i++) begin
            compare($sformatf("s_ar[%0d]", i), 64'(e.s_ar[i]), 64'(s_ar[i]));
            compare($sformatf("s_aw[%0d]", i), 64'(e.s_aw[i]), 64'(s_aw[i]));
            compare($sformatf("s_w[%0d]", i), 64'(e.s_w[i]), 64'(s_w[i]));
        end
    end

endmodule

//--- test/axi_id_xbar_tb.sv
`timescale 1ns/1ps

module axi_id_xbar_tb import axi_xbar_pkg::*; ();

    logic                  aclk;
    logic                  reset;
    logic [31:0]           lfsr_state;
    int                    timeouts;
    int                    error_count;
    int                    check_count;

    // master side
    addr_req_t             m0_ar;
    addr_req_t             m1_ar;
    addr_req_t             m1_aw;
    w_beat_t               m1_w;
    r_beat_t               m0_r;
    r_beat_t               m1_r;
    b_beat_t               m1_b;
    logic                  m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic                  m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic                  m1_awvalid, m1_awready, m1_wvalid, m1_wready;
    logic                  m1_bvalid, m1_bready;

    // slave side
    addr_req_t             s_ar [NUM_SLAVES];
    addr_req_t             s_aw [NUM_SLAVES];
    w_beat_t               s_w [NUM_SLAVES];
    r_beat_t               s_r [NUM_SLAVES];
    b_beat_t               s_b [NUM_SLAVES];
    logic [NUM_SLAVES-1:0] s_arvalid, s_arready, s_awvalid, s_awready;
    logic [NUM_SLAVES-1:0] s_wvalid, s_wready, s_rvalid, s_rready, s_bvalid, s_bready;

    axi_id_xbar u_axi_id_xbar (.*);

    axi_id_xbar_checker u_checker (.*);

    bind axi_id_xbar axi_id_xbar_assert u_assert (
        .aclk      (aclk),
        .reset     (reset),
        .s_arvalid (s_arvalid),
        .s_awvalid (s_awvalid),
        .s_wvalid  (s_wvalid),
        .m0_rvalid (m0_rvalid),
        .m1_rvalid (m1_rvalid)
    );

    always #2 aclk = ~aclk;

    //**************************************************
    // random source
    //**************************************************
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic take_bit();
        return 1'(take_bits(1));
    endfunction

    // three known codes and two that select nobody
    function automatic route_t pick_code();
        logic [31:0] k;
        k = take_bits(3) % 5;
        case (k)
            32'd0:   return 3'b001;
            32'd1:   return 3'b011;
            32'd2:   return 3'b111;
            32'd3:   return 3'b000;
            default: return 3'b010;
        endcase
    endfunction

    function automatic id_t random_id();
        return {pick_code(), pick_code()};
    endfunction

    function automatic logic is_routed(id_t id);
        logic lo_ok;
        logic hi_ok;
        lo_ok = (id[2:0] == 3'b001) || (id[2:0] == 3'b011) || (id[2:0] == 3'b111);
        hi_ok = (id[5:3] == 3'b001) || (id[5:3] == 3'b011) || (id[5:3] == 3'b111);
        return lo_ok && hi_ok;
    endfunction

    //**************************************************
    // stimulus
    //**************************************************
    task automatic drive_idle();
        m0_ar      = '0;
        m1_ar      = '0;
        m1_aw      = '0;
        m1_w       = '0;
        m0_arvalid = 1'b0;
        m1_arvalid = 1'b0;
        m1_awvalid = 1'b0;
        m1_wvalid  = 1'b0;
        m0_rready  = 1'b0;
        m1_rready  = 1'b0;
        m1_bready  = 1'b0;
        s_arready  = '0;
        s_awready  = '0;
        s_wready   = '0;
        s_rvalid   = '0;
        s_bvalid   = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_r[i] = '0;
            s_b[i] = '0;
        end
    endtask

    // chans bits: read address, read data, write request, write response
    task automatic drive_cycle(input logic [3:0] chans, output int hit);
        id_t id;
        int  k;
        drive_idle();
        hit = 0;
        if (chans[0]) begin
            // one master asks, the other keeps a zero ARID
            id = random_id();
            if (take_bit()) begin
                m0_ar = {take_bits(32), 9'(take_bits(9)), id};
                m1_ar = {take_bits(32), 9'(take_bits(9)), id_t'(0)};
            end else begin
                m0_ar = {take_bits(32), 9'(take_bits(9)), id_t'(0)};
                m1_ar = {take_bits(32), 9'(take_bits(9)), id};
            end
            m0_arvalid = take_bit();
            m1_arvalid = take_bit();
            s_arready  = 3'(take_bits(3));
            if (is_routed(id)) hit++;
        end
        if (chans[1]) begin
            id = random_id();
            k  = int'(take_bits(2) % 3);
            for (int i = 0; i < NUM_SLAVES; i++) begin
                s_r[i] = {take_bits(32), 3'(take_bits(3)), (i == k) ? id : id_t'(0)};
            end
            s_rvalid  = 3'(take_bits(3));
            m0_rready = take_bit();
            m1_rready = take_bit();
            if (is_routed(id)) hit++;
        end
        if (chans[2]) begin
            // address and data IDs drawn apart
            id = random_id();
            m1_aw      = {take_bits(32), 9'(take_bits(9)), id};
            m1_w       = {take_bits(32), 5'(take_bits(5)), random_id()};
            m1_awvalid = take_bit();
            m1_wvalid  = take_bit();
            s_awready  = 3'(take_bits(3));
            s_wready   = 3'(take_bits(3));
            if (is_routed(id)) hit++;
        end
        if (chans[3]) begin
            id = random_id();
            k  = int'(take_bits(2) % 3);
            for (int i = 0; i < NUM_SLAVES; i++) begin
                s_b[i] = {2'(take_bits(2)), (i == k) ? id : id_t'(0)};
            end
            s_bvalid  = 3'(take_bits(3));
            m1_bready = take_bit();
            if (is_routed(id)) hit++;
        end
    endtask

    task automatic run_phase(input string name, input logic [3:0] chans, input int target,
                             input int limit);
        int hits;
        int cycles;
        int hit;
        hits = 0;
        cycles = 0;
        while (hits < target && cycles < limit) begin
            @(posedge aclk);
            #1;
            drive_cycle(chans, hit);
            hits += hit;
            cycles++;
        end
        if (hits < target) begin
            $display("Timeout: phase %s routed only %0d of %0d requests in %0d cycles",
                     name, hits, target, limit);
            timeouts++;
        end
    endtask

    initial begin
        aclk       = 1'b0;
        reset      = 1'b1;
        lfsr_state = 32'h2678;
        timeouts   = 0;
        drive_idle();
        repeat (10) @(posedge aclk);
        #1;
        reset = 1'b0;

        run_phase("read address", 4'b0001, 60, 400);
        run_phase("read data", 4'b0010, 60, 400);
        run_phase("write request", 4'b0100, 60, 400);
        run_phase("write response", 4'b1000, 60, 400);
        run_phase("mixed traffic", 4'b1111, 200, 2000);

        // last cycle gets sampled before the counts are read
        @(posedge aclk);
        #1;
        drive_idle();
        @(posedge aclk);
        #1;

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
